/* hc_macros.svh */
`ifndef HC_MACROS_SVH
`define HC_MACROS_SVH

// word address and data word widths
`define HC_ADDR_BITS 32
`define HC_DATA_BITS 32

// number of fully associative lines
`define HC_NUM_LINES 8

// words per line, must be a power of two
`define HC_LINE_WORDS 4

// saturating hit counter used for LFU replacement
`define HC_HITCNT_BITS 8

// pending requests per side before ready drops
`define HC_QUEUE_DEPTH 4

// derived widths
`define HC_OFFSET_BITS ($clog2(`HC_LINE_WORDS))
`define HC_IDX_BITS ($clog2(`HC_NUM_LINES))

`endif

/* hc_bus_pkg.sv */
`include "hc_macros.svh"

package hc_bus_pkg;

	// all addresses are word addresses
	typedef logic [`HC_ADDR_BITS-1:0] addr_t;

	typedef logic [`HC_DATA_BITS-1:0] data_t;

endpackage

/* hc_line_pkg.sv */
`include "hc_macros.svh"

package hc_line_pkg;

	typedef logic [`HC_OFFSET_BITS-1:0] offset_t;

	// region number, the address without its word offset
	typedef logic [`HC_ADDR_BITS-`HC_OFFSET_BITS-1:0] tag_t;

	typedef logic [`HC_IDX_BITS-1:0] line_idx_t;
	typedef logic [`HC_HITCNT_BITS-1:0] hitcnt_t;

	typedef enum logic [2:0] {
		IDLE      = 3'b000,
		WRITEBACK = 3'b001,
		FILL_REQ  = 3'b010,
		FILL_WAIT = 3'b011,
		INSTALL   = 3'b100
	} refill_state_t;

endpackage

/* hc_request_queue.sv */
`timescale 1ns/1ps
`include "hc_macros.svh"

module hc_request_queue #(
	parameter int WIDTH = 32,
	parameter int DEPTH = `HC_QUEUE_DEPTH
) (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             push,
	input  logic [WIDTH-1:0] wdata,
	input  logic             pop,
	output logic [WIDTH-1:0] head,
	output logic             head_valid,
	output logic             ready
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_BITS-1:0] LAST = PTR_BITS'(DEPTH - 1);

	logic [WIDTH-1:0]    entries [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	assign ready = (count != (PTR_BITS + 1)'(DEPTH));
	assign head_valid = (count != '0);
	assign head = entries[rd_ptr];

	// push when full and pop when empty are dropped
	assign do_push = push && ready;
	assign do_pop = pop && head_valid;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= wdata;
	end

endmodule

/* hc_line_array.sv */
`timescale 1ns/1ps
`include "hc_macros.svh"

module hc_line_array (
	input  logic                                 clk,
	input  logic                                 reset_n,
	input  logic [`HC_ADDR_BITS+`HC_DATA_BITS:0] dq_head,
	input  logic                                 dq_valid,
	input  hc_bus_pkg::addr_t                    iq_head,
	input  logic                                 iq_valid,
	input  logic                                 busy,
	input  hc_line_pkg::line_idx_t               line_sel,
	input  hc_line_pkg::offset_t                 word_sel,
	input  logic                                 word_we,
	input  hc_bus_pkg::data_t                    word_wdata,
	input  logic                                 install,
	output logic                                 dq_pop,
	output logic                                 iq_pop,
	output hc_bus_pkg::data_t                    dcache_out,
	output hc_bus_pkg::data_t                    icache_out,
	output logic                                 dcache_out_valid,
	output logic                                 icache_out_valid,
	output logic                                 miss,
	output hc_bus_pkg::addr_t                    miss_addr,
	output logic [`HC_NUM_LINES-1:0]             line_valid,
	output logic [`HC_NUM_LINES-1:0]             line_dirty,
	output hc_line_pkg::hitcnt_t [`HC_NUM_LINES-1:0] hit_counts,
	output hc_line_pkg::tag_t                    sel_tag,
	output hc_bus_pkg::data_t                    sel_rdata
);

	hc_line_pkg::tag_t      tags [`HC_NUM_LINES];
	hc_bus_pkg::data_t      words [`HC_NUM_LINES][`HC_LINE_WORDS];
	hc_line_pkg::tag_t      refill_tag;
	logic                   dq_write;
	hc_bus_pkg::addr_t      dq_addr;
	hc_bus_pkg::data_t      dq_wdata;
	logic                   lookup;
	logic                   is_write;
	logic                   hit;
	hc_line_pkg::line_idx_t hit_idx;
	hc_line_pkg::tag_t      look_tag;
	hc_line_pkg::offset_t   look_off;
	hc_bus_pkg::data_t      hit_rdata;

	// queue entry is {write flag, address, data}
	assign dq_write = dq_head[`HC_ADDR_BITS+`HC_DATA_BITS];
	assign dq_addr = dq_head[`HC_ADDR_BITS+`HC_DATA_BITS-1:`HC_DATA_BITS];
	assign dq_wdata = dq_head[`HC_DATA_BITS-1:0];

	// data side first, nothing is looked up during a refill
	assign lookup = !busy && (dq_valid || iq_valid);
	assign is_write = dq_valid && dq_write;
	assign miss_addr = dq_valid ? dq_addr : iq_head;
	assign look_tag = miss_addr[`HC_ADDR_BITS-1:`HC_OFFSET_BITS];
	assign look_off = miss_addr[`HC_OFFSET_BITS-1:0];

	// tags of valid lines are unique, so at most one line matches
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < `HC_NUM_LINES; i++) begin
			if (line_valid[i] && tags[i] == look_tag) begin
				hit = 1'b1;
				hit_idx = hc_line_pkg::line_idx_t'(i);
			end
		end
	end

	assign hit_rdata = words[hit_idx][look_off];

	assign miss = lookup && !hit;
	assign dq_pop = lookup && hit && dq_valid;
	assign iq_pop = lookup && hit && !dq_valid;

	// word port for the refill controller
	assign sel_tag = tags[line_sel];
	assign sel_rdata = words[line_sel][word_sel];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			line_valid <= '0;
			line_dirty <= '0;
			hit_counts <= '0;
			dcache_out_valid <= 1'b0;
			icache_out_valid <= 1'b0;
		end else begin
			// writes give no response
			dcache_out_valid <= dq_pop && !dq_write;
			icache_out_valid <= iq_pop;
			if (lookup && hit) begin
				if (hit_counts[hit_idx] != '1)
					hit_counts[hit_idx] <= hit_counts[hit_idx] + 1'b1;
				if (is_write)
					line_dirty[hit_idx] <= 1'b1;
			end
			if (install) begin
				line_valid[line_sel] <= 1'b1;
				line_dirty[line_sel] <= 1'b0;
				hit_counts[line_sel] <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		// head may change while busy, keep the region that missed
		if (miss)
			refill_tag <= look_tag;
		if (install)
			tags[line_sel] <= refill_tag;
		if (lookup && hit && is_write)
			words[hit_idx][look_off] <= dq_wdata;
		if (word_we)
			words[line_sel][word_sel] <= word_wdata;
		if (dq_pop && !dq_write)
			dcache_out <= hit_rdata;
		if (iq_pop)
			icache_out <= hit_rdata;
	end

endmodule

/* hc_refill_ctrl.sv */
`timescale 1ns/1ps
`include "hc_macros.svh"

module hc_refill_ctrl (
	input  logic                                 clk,
	input  logic                                 reset_n,
	input  logic                                 miss,
	input  hc_bus_pkg::addr_t                    miss_addr,
	input  logic [`HC_NUM_LINES-1:0]             line_valid,
	input  logic [`HC_NUM_LINES-1:0]             line_dirty,
	input  hc_line_pkg::hitcnt_t [`HC_NUM_LINES-1:0] hit_counts,
	input  hc_line_pkg::tag_t                    sel_tag,
	input  hc_bus_pkg::data_t                    sel_rdata,
	input  hc_bus_pkg::data_t                    mem_out,
	input  logic                                 mem_out_valid,
	output logic                                 busy,
	output hc_line_pkg::line_idx_t               line_sel,
	output hc_line_pkg::offset_t                 word_sel,
	output logic                                 word_we,
	output hc_bus_pkg::data_t                    word_wdata,
	output logic                                 install,
	output hc_bus_pkg::addr_t                    mem_addr,
	output hc_bus_pkg::data_t                    mem_in,
	output logic                                 mem_wrreq,
	output logic                                 mem_rdreq
);

	hc_line_pkg::refill_state_t state;
	hc_line_pkg::offset_t       word_cnt;
	hc_line_pkg::line_idx_t     victim;
	hc_line_pkg::tag_t          fill_tag;
	hc_line_pkg::line_idx_t     lfu_idx;
	hc_line_pkg::hitcnt_t       lfu_cnt;
	logic                       found_free;
	logic                       last_word;

	// LFU victim: first invalid line, else lowest count, lowest index on a tie
	always_comb begin
		found_free = 1'b0;
		lfu_idx = '0;
		lfu_cnt = hit_counts[0];
		for (int i = 0; i < `HC_NUM_LINES; i++) begin
			if (!line_valid[i] && !found_free) begin
				found_free = 1'b1;
				lfu_idx = hc_line_pkg::line_idx_t'(i);
			end
		end
		if (!found_free) begin
			for (int i = 1; i < `HC_NUM_LINES; i++) begin
				if (hit_counts[i] < lfu_cnt) begin
					lfu_cnt = hit_counts[i];
					lfu_idx = hc_line_pkg::line_idx_t'(i);
				end
			end
		end
	end

	assign busy = (state != hc_line_pkg::IDLE);
	assign line_sel = victim;
	assign word_sel = word_cnt;
	assign last_word = (word_cnt == hc_line_pkg::offset_t'(`HC_LINE_WORDS - 1));

	// returned words go straight into the victim line
	assign word_we = (state == hc_line_pkg::FILL_WAIT) && mem_out_valid;
	assign word_wdata = mem_out;
	assign install = (state == hc_line_pkg::INSTALL);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= hc_line_pkg::IDLE;
			word_cnt <= '0;
			mem_wrreq <= 1'b0;
			mem_rdreq <= 1'b0;
		end else begin
			mem_wrreq <= 1'b0;
			mem_rdreq <= 1'b0;
			case (state)
				hc_line_pkg::IDLE: begin
					if (miss) begin
						word_cnt <= '0;
						state <= line_dirty[lfu_idx] ? hc_line_pkg::WRITEBACK
							: hc_line_pkg::FILL_REQ;
					end
				end
				hc_line_pkg::WRITEBACK: begin
					// one write per cycle, counter wraps to zero for the fill
					mem_wrreq <= 1'b1;
					word_cnt <= word_cnt + 1'b1;
					if (last_word)
						state <= hc_line_pkg::FILL_REQ;
				end
				hc_line_pkg::FILL_REQ: begin
					mem_rdreq <= 1'b1;
					state <= hc_line_pkg::FILL_WAIT;
				end
				hc_line_pkg::FILL_WAIT: begin
					if (mem_out_valid) begin
						word_cnt <= word_cnt + 1'b1;
						state <= last_word ? hc_line_pkg::INSTALL : hc_line_pkg::FILL_REQ;
					end
				end
				hc_line_pkg::INSTALL: begin
					state <= hc_line_pkg::IDLE;
				end
				default: begin
					state <= hc_line_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == hc_line_pkg::IDLE && miss) begin
			victim <= lfu_idx;
			fill_tag <= miss_addr[`HC_ADDR_BITS-1:`HC_OFFSET_BITS];
		end
		// old region address comes from the victim's tag
		if (state == hc_line_pkg::WRITEBACK) begin
			mem_addr <= {sel_tag, word_cnt};
			mem_in <= sel_rdata;
		end else if (state == hc_line_pkg::FILL_REQ) begin
			mem_addr <= {fill_tag, word_cnt};
		end
	end

endmodule

/* hybrid_cache.sv */
`timescale 1ns/1ps
`include "hc_macros.svh"

module hybrid_cache (
	input  logic              clk,
	input  logic              reset_n,

	// data side, reads and writes share one queue
	input  hc_bus_pkg::addr_t dcache_addr,
	input  logic              dcache_rdreq,
	input  logic              dcache_wrreq,
	input  hc_bus_pkg::data_t dcache_in,
	output logic              dcache_ready,
	output hc_bus_pkg::data_t dcache_out,
	output logic              dcache_out_valid,

	// instruction side
	input  hc_bus_pkg::addr_t icache_addr,
	input  logic              icache_rdreq,
	output logic              icache_ready,
	output hc_bus_pkg::data_t icache_out,
	output logic              icache_out_valid,

	// memory port
	output hc_bus_pkg::addr_t mem_addr,
	output hc_bus_pkg::data_t mem_in,
	output logic              mem_wrreq,
	output logic              mem_rdreq,
	input  hc_bus_pkg::data_t mem_out,
	input  logic              mem_out_valid
);

	logic [`HC_ADDR_BITS+`HC_DATA_BITS:0]      dq_head;
	logic                                      dq_valid;
	logic                                      dq_pop;
	hc_bus_pkg::addr_t                         iq_head;
	logic                                      iq_valid;
	logic                                      iq_pop;
	logic                                      busy;
	hc_line_pkg::line_idx_t                    line_sel;
	hc_line_pkg::offset_t                      word_sel;
	logic                                      word_we;
	hc_bus_pkg::data_t                         word_wdata;
	logic                                      install;
	logic                                      miss;
	hc_bus_pkg::addr_t                         miss_addr;
	logic [`HC_NUM_LINES-1:0]                  line_valid;
	logic [`HC_NUM_LINES-1:0]                  line_dirty;
	hc_line_pkg::hitcnt_t [`HC_NUM_LINES-1:0]  hit_counts;
	hc_line_pkg::tag_t                         sel_tag;
	hc_bus_pkg::data_t                         sel_rdata;

	hc_request_queue #(
		.WIDTH(`HC_ADDR_BITS + `HC_DATA_BITS + 1)
	) data_queue (
		.clk(clk),
		.reset_n(reset_n),
		.push(dcache_rdreq | dcache_wrreq),
		.wdata({dcache_wrreq, dcache_addr, dcache_in}),
		.pop(dq_pop),
		.head(dq_head),
		.head_valid(dq_valid),
		.ready(dcache_ready)
	);

	hc_request_queue #(
		.WIDTH(`HC_ADDR_BITS)
	) instr_queue (
		.clk(clk),
		.reset_n(reset_n),
		.push(icache_rdreq),
		.wdata(icache_addr),
		.pop(iq_pop),
		.head(iq_head),
		.head_valid(iq_valid),
		.ready(icache_ready)
	);

	hc_line_array line_array (
		.clk(clk),
		.reset_n(reset_n),
		.dq_head(dq_head),
		.dq_valid(dq_valid),
		.iq_head(iq_head),
		.iq_valid(iq_valid),
		.busy(busy),
		.line_sel(line_sel),
		.word_sel(word_sel),
		.word_we(word_we),
		.word_wdata(word_wdata),
		.install(install),
		.dq_pop(dq_pop),
		.iq_pop(iq_pop),
		.dcache_out(dcache_out),
		.icache_out(icache_out),
		.dcache_out_valid(dcache_out_valid),
		.icache_out_valid(icache_out_valid),
		.miss(miss),
		.miss_addr(miss_addr),
		.line_valid(line_valid),
		.line_dirty(line_dirty),
		.hit_counts(hit_counts),
		.sel_tag(sel_tag),
		.sel_rdata(sel_rdata)
	);

	hc_refill_ctrl refill_ctrl (
		.clk(clk),
		.reset_n(reset_n),
		.miss(miss),
		.miss_addr(miss_addr),
		.line_valid(line_valid),
		.line_dirty(line_dirty),
		.hit_counts(hit_counts),
		.sel_tag(sel_tag),
		.sel_rdata(sel_rdata),
		.mem_out(mem_out),
		.mem_out_valid(mem_out_valid),
		.busy(busy),
		.line_sel(line_sel),
		.word_sel(word_sel),
		.word_we(word_we),
		.word_wdata(word_wdata),
		.install(install),
		.mem_addr(mem_addr),
		.mem_in(mem_in),
		.mem_wrreq(mem_wrreq),
		.mem_rdreq(mem_rdreq)
	);

endmodule

/* hybrid_cache_assert.sv */
`timescale 1ns/1ps

module hybrid_cache_assert (
	input logic clk,
	input logic reset_n,
	input logic mem_wrreq,
	input logic mem_rdreq,
	input logic mem_out_valid,
	input logic dcache_rdreq,
	input logic dcache_ready,
	input logic icache_rdreq,
	input logic icache_ready,
	input logic dcache_out_valid,
	input logic icache_out_valid
);

	logic       rd_open;
	logic [3:0] d_open;
	logic [3:0] i_open;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			rd_open <= 1'b0;
		else if (mem_rdreq)
			rd_open <= 1'b1;
		else if (mem_out_valid)
			rd_open <= 1'b0;
	end

	// reads accepted at the ports and not yet answered
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			d_open <= '0;
			i_open <= '0;
		end else begin
			d_open <= d_open + 4'(dcache_rdreq && dcache_ready) - 4'(dcache_out_valid);
			i_open <= i_open + 4'(icache_rdreq && icache_ready) - 4'(icache_out_valid);
		end
	end

	strobe_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(mem_rdreq && mem_wrreq))
		else $error("mem_rdreq and mem_wrreq high in the same cycle");

	single_read: assert property (@(posedge clk) disable iff (!reset_n)
		mem_rdreq |-> !rd_open)
		else $error("mem_rdreq issued while a read is outstanding");

	// every valid cycle uses up one accepted read, a stuck valid runs out
	dvalid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		dcache_out_valid |-> (d_open != '0))
		else $error("dcache_out_valid with no data read outstanding");

	ivalid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
		icache_out_valid |-> (i_open != '0))
		else $error("icache_out_valid with no instruction read outstanding");

endmodule

bind hybrid_cache hybrid_cache_assert hybrid_cache_assert_inst (
	.clk(clk),
	.reset_n(reset_n),
	.mem_wrreq(mem_wrreq),
	.mem_rdreq(mem_rdreq),
	.mem_out_valid(mem_out_valid),
	.dcache_rdreq(dcache_rdreq),
	.dcache_ready(dcache_ready),
	.icache_rdreq(icache_rdreq),
	.icache_ready(icache_ready),
	.dcache_out_valid(dcache_out_valid),
	.icache_out_valid(icache_out_valid)
);

/* tb_hybrid_cache.sv */
`timescale 1ns/1ps
`include "hc_macros.svh"

module tb_hybrid_cache;

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 8;
	localparam int DRAIN_TIMEOUT = 4000;
	localparam int NUM_REGIONS = 24;
	localparam hc_bus_pkg::addr_t DATA_BASE = 32'h0000_1000;
	localparam hc_bus_pkg::addr_t INSTR_BASE = 32'h8000_2000;
	localparam hc_bus_pkg::data_t INIT_KEY = 32'h5a5a_0000;

	logic              clk;
	logic              reset_n;
	hc_bus_pkg::addr_t dcache_addr;
	logic              dcache_rdreq;
	logic              dcache_wrreq;
	hc_bus_pkg::data_t dcache_in;
	logic              dcache_ready;
	hc_bus_pkg::data_t dcache_out;
	logic              dcache_out_valid;
	hc_bus_pkg::addr_t icache_addr;
	logic              icache_rdreq;
	logic              icache_ready;
	hc_bus_pkg::data_t icache_out;
	logic              icache_out_valid;
	hc_bus_pkg::addr_t mem_addr;
	hc_bus_pkg::data_t mem_in;
	logic              mem_wrreq;
	logic              mem_rdreq;
	hc_bus_pkg::data_t mem_out;
	logic              mem_out_valid;

	logic [31:0]       lcg_state;
	logic              slow_mem;
	hc_bus_pkg::data_t ref_mem [hc_bus_pkg::addr_t];
	hc_bus_pkg::data_t mem_model [hc_bus_pkg::addr_t];
	hc_bus_pkg::data_t d_expect [$];
	hc_bus_pkg::data_t i_expect [$];
	int                d_reads;
	int                i_reads;
	int                d_resps;
	int                i_resps;
	int                wb_words;
	int                d_full;
	int                i_full;

	hybrid_cache hybrid_cache_inst (
		.clk(clk),
		.reset_n(reset_n),
		.dcache_addr(dcache_addr),
		.dcache_rdreq(dcache_rdreq),
		.dcache_wrreq(dcache_wrreq),
		.dcache_in(dcache_in),
		.dcache_ready(dcache_ready),
		.dcache_out(dcache_out),
		.dcache_out_valid(dcache_out_valid),
		.icache_addr(icache_addr),
		.icache_rdreq(icache_rdreq),
		.icache_ready(icache_ready),
		.icache_out(icache_out),
		.icache_out_valid(icache_out_valid),
		.mem_addr(mem_addr),
		.mem_in(mem_in),
		.mem_wrreq(mem_wrreq),
		.mem_rdreq(mem_rdreq),
		.mem_out(mem_out),
		.mem_out_valid(mem_out_valid)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// one of 24 regions above base, word inside the line from two bits
	function automatic hc_bus_pkg::addr_t pick_addr(input hc_bus_pkg::addr_t base,
			input logic [31:0] r);
		int region;
		region = int'(r[23:16]) % NUM_REGIONS;
		return base + hc_bus_pkg::addr_t'(region * `HC_LINE_WORDS)
			+ hc_bus_pkg::addr_t'(r[29:28]);
	endfunction

	// last written value, else the initial memory content
	function automatic hc_bus_pkg::data_t expected_read(input hc_bus_pkg::addr_t addr);
		if (ref_mem.exists(addr))
			return ref_mem[addr];
		else
			return addr ^ INIT_KEY;
	endfunction

	function automatic hc_bus_pkg::data_t mem_word(input hc_bus_pkg::addr_t addr);
		if (mem_model.exists(addr))
			return mem_model[addr];
		else
			return addr ^ INIT_KEY;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("Mismatch %s: got 0x%08h expected 0x%08h", name, got, expected));
	endtask

	task automatic check_idle();
		check_value("dcache_ready", 32'(dcache_ready), 32'd1);
		check_value("icache_ready", 32'(icache_ready), 32'd1);
		check_value("mem_wrreq", 32'(mem_wrreq), 32'd0);
		check_value("mem_rdreq", 32'(mem_rdreq), 32'd0);
		check_value("dcache_out_valid", 32'(dcache_out_valid), 32'd0);
		check_value("icache_out_valid", 32'(icache_out_valid), 32'd0);
	endtask

	// rate is out of 16 per side and cycle
	task automatic drive_cycle(input logic [3:0] rate);
		logic [31:0]       r;
		hc_bus_pkg::addr_t addr;
		hc_bus_pkg::data_t wdata;
		@(posedge clk);
		#2;
		dcache_rdreq = 1'b0;
		dcache_wrreq = 1'b0;
		icache_rdreq = 1'b0;
		r = next_rand();
		if (r[19:16] < rate && dcache_ready) begin
			addr = pick_addr(DATA_BASE, next_rand());
			wdata = next_rand();
			dcache_addr = addr;
			dcache_in = wdata;
			if (r[20]) begin
				dcache_wrreq = 1'b1;
				ref_mem[addr] = wdata;
			end else begin
				dcache_rdreq = 1'b1;
				d_expect.push_back(expected_read(addr));
				d_reads++;
			end
		end
		if (r[27:24] < rate && icache_ready) begin
			addr = pick_addr(INSTR_BASE, next_rand());
			icache_addr = addr;
			icache_rdreq = 1'b1;
			i_expect.push_back(addr ^ INIT_KEY);
			i_reads++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// single outstanding read, answered after the chosen latency
	initial begin : memory_model
		hc_bus_pkg::addr_t rd_addr;
		int                rd_wait;
		logic [31:0]       r;
		rd_addr = '0;
		rd_wait = 0;
		mem_out = '0;
		mem_out_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (reset_n && mem_wrreq) begin
				check_value("mem_addr[31]", 32'(mem_addr[31]), 32'd0);
				mem_model[mem_addr] = mem_in;
				wb_words++;
			end
			if (reset_n && mem_rdreq) begin
				r = next_rand();
				rd_addr = mem_addr;
				rd_wait = slow_mem ? 4 : 1 + int'(r[25:24]);
			end
			@(posedge clk);
			#2;
			mem_out_valid = 1'b0;
			if (rd_wait > 0) begin
				rd_wait--;
				if (rd_wait == 0) begin
					mem_out = mem_word(rd_addr);
					mem_out_valid = 1'b1;
				end
			end
		end
	end

	initial begin : response_monitor
		forever begin
			@(negedge clk);
			if (reset_n) begin
				if (!dcache_ready)
					d_full++;
				if (!icache_ready)
					i_full++;
				if (dcache_out_valid) begin
					if (d_expect.size() == 0)
						fail_run("data response arrived with no data read pending");
					else
						check_value("dcache_out", dcache_out, d_expect.pop_front());
					d_resps++;
				end
				if (icache_out_valid) begin
					if (i_expect.size() == 0)
						fail_run("instruction response arrived with no read pending");
					else
						check_value("icache_out", icache_out, i_expect.pop_front());
					i_resps++;
				end
			end
		end
	end

	initial begin
		int wait_cycles;
		lcg_state = 32'ha1c925ec;
		slow_mem = 1'b0;
		reset_n = 1'b0;
		dcache_addr = '0;
		dcache_rdreq = 1'b0;
		dcache_wrreq = 1'b0;
		dcache_in = '0;
		icache_addr = '0;
		icache_rdreq = 1'b0;
		d_reads = 0;
		i_reads = 0;
		d_resps = 0;
		i_resps = 0;
		wb_words = 0;
		d_full = 0;
		i_full = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset_n = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_idle();
		end

		// mixed traffic, then dense traffic against slow memory
		repeat (600) drive_cycle(4'd8);
		slow_mem = 1'b1;
		repeat (400) drive_cycle(4'd14);
		@(posedge clk);
		#2;
		dcache_rdreq = 1'b0;
		dcache_wrreq = 1'b0;
		icache_rdreq = 1'b0;

		wait_cycles = 0;
		while ((d_resps != d_reads || i_resps != i_reads) && wait_cycles < DRAIN_TIMEOUT) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (d_resps != d_reads || i_resps != i_reads)
			fail_run("timeout waiting for all read responses to return");
		// late extra responses are caught by the monitor
		repeat (20) @(posedge clk);

		check_value("write-back seen", 32'(wb_words != 0), 32'd1);
		check_value("dcache_ready low seen", 32'(d_full != 0), 32'd1);
		check_value("icache_ready low seen", 32'(i_full != 0), 32'd1);
		$display("Verification passed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
hc_bus_pkg.sv
hc_line_pkg.sv
hc_request_queue.sv
hc_line_array.sv
hc_refill_ctrl.sv
hybrid_cache.sv
hybrid_cache_assert.sv
tb_hybrid_cache.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_hybrid_cache
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) hc_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
